// ==== compile.f ====
design/rvv_pkg.sv
design/rvv_issue.sv
design/rvv_csr.sv
design/rvv_vregs.sv
design/rvv_mem_seq.sv
design/rvv_coproc_top.sv
dv/rvv_coproc_asserts.sv
dv/rvv_coproc_tb.sv

// ==== design/rvv_coproc_top.sv ====
`timescale 1ns/1ps

module rvv_coproc_top (
	input  logic           clk,
	input  logic           resetn,
	input  logic           pcpi_valid_i,
	input  rvv_pkg::word_t pcpi_insn_i,
	input  rvv_pkg::word_t pcpi_rs1_i,
	input  rvv_pkg::word_t pcpi_rs2_i,
	output logic           pcpi_wr_o,
	output rvv_pkg::word_t pcpi_rd_o,
	output logic           pcpi_wait_o,
	output logic           pcpi_ready_o,
	output logic           pcpi_is_rvv_o,
	output logic           mem_req_o,
	output logic           mem_store_o,
	output rvv_pkg::word_t mem_addr_o,
	output rvv_pkg::word_t mem_wdata_o,
	output logic [3:0]     mem_strb_o,
	input  rvv_pkg::word_t mem_rdata_i,
	input  logic           mem_done_i
);

	logic                cfg_we;
	rvv_pkg::cfg_kind_e  cfg_kind;
	logic                seq_start;
	logic                seq_store;
	logic                seq_done;
	rvv_pkg::vl_t        vl;
	rvv_pkg::vreg_addr_t vregs_raddr;
	rvv_pkg::vreg_t      vregs_rdata;
	logic                vregs_we;
	rvv_pkg::vreg_addr_t vregs_waddr;
	rvv_pkg::vreg_t      vregs_wdata;
	rvv_pkg::vreg_t      v0;

	rvv_issue u_issue (
		.clk          (clk),
		.resetn       (resetn),
		.pcpi_valid_i (pcpi_valid_i),
		.insn_i       (pcpi_insn_i),
		.vl_i         (vl),
		.seq_done_i   (seq_done),
		.is_rvv_o     (pcpi_is_rvv_o),
		.cfg_we_o     (cfg_we),
		.cfg_kind_o   (cfg_kind),
		.seq_start_o  (seq_start),
		.seq_store_o  (seq_store),
		.pcpi_wait_o  (pcpi_wait_o),
		.pcpi_ready_o (pcpi_ready_o),
		.pcpi_wr_o    (pcpi_wr_o),
		.pcpi_rd_o    (pcpi_rd_o)
	);

	rvv_csr u_csr (
		.clk        (clk),
		.resetn     (resetn),
		.cfg_we_i   (cfg_we),
		.cfg_kind_i (cfg_kind),
		.insn_i     (pcpi_insn_i),
		.rs1_i      (pcpi_rs1_i),
		.rs2_i      (pcpi_rs2_i),
		.vl_o       (vl)
	);

	rvv_vregs u_vregs (
		.clk     (clk),
		.resetn  (resetn),
		.raddr_i (vregs_raddr),
		.rdata_o (vregs_rdata),
		.we_i    (vregs_we),
		.waddr_i (vregs_waddr),
		.wdata_i (vregs_wdata),
		.v0_o    (v0)
	);

	// vd/vs3 in insn[11:7], vm in insn[25], base from rs1
	rvv_mem_seq u_mem_seq (
		.clk         (clk),
		.resetn      (resetn),
		.start_i     (seq_start),
		.store_i     (seq_store),
		.vd_i        (pcpi_insn_i[11:7]),
		.vm_i        (pcpi_insn_i[25]),
		.base_i      (pcpi_rs1_i),
		.vl_i        (vl),
		.v0_i        (v0),
		.raddr_o     (vregs_raddr),
		.rdata_i     (vregs_rdata),
		.we_o        (vregs_we),
		.waddr_o     (vregs_waddr),
		.wdata_o     (vregs_wdata),
		.mem_req_o   (mem_req_o),
		.mem_store_o (mem_store_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_strb_o  (mem_strb_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_done_i  (mem_done_i),
		.done_o      (seq_done)
	);

endmodule

// ==== design/rvv_csr.sv ====
`timescale 1ns/1ps

module rvv_csr (
	input  logic               clk,
	input  logic               resetn,
	input  logic               cfg_we_i,
	input  rvv_pkg::cfg_kind_e cfg_kind_i,
	input  rvv_pkg::word_t     insn_i,
	input  rvv_pkg::word_t     rs1_i,
	input  rvv_pkg::word_t     rs2_i,
	output rvv_pkg::vl_t       vl_o
);

	rvv_pkg::vtype_t vtype_q;
	rvv_pkg::vtype_t vtype_new;
	rvv_pkg::vtype_t vtype_next;
	rvv_pkg::vl_t    vl_q;
	rvv_pkg::vl_t    vl_next;
	rvv_pkg::word_t  avl;
	logic [15:0]     vlmax_base; // elements per register at this sew
	logic [15:0]     vlmax;
	logic [3:0]      sew_shift;

	// immediate forms carry vtype in insn[27:20]
	assign vtype_new = (cfg_kind_i == rvv_pkg::CFG_VSETVL) ? rs2_i : {24'b0, insn_i[27:20]};

	assign sew_shift  = {1'b0, vtype_new[5:3]} + 4'd3;
	assign vlmax_base = 16'(rvv_pkg::VLEN) >> sew_shift;

	always_comb begin
		case (vtype_new[2:0])
			3'b100:  vlmax = '0;              // reserved lmul
			3'b101:  vlmax = vlmax_base >> 3; // mf8
			3'b110:  vlmax = vlmax_base >> 2;
			3'b111:  vlmax = vlmax_base >> 1;
			default: vlmax = vlmax_base << vtype_new[2:0];
		endcase
	end

	// avl selection
	always_comb begin
		if (cfg_kind_i == rvv_pkg::CFG_VSETIVLI)
			avl = {27'b0, insn_i[19:15]};
		else if (insn_i[19:15] != 5'd0)
			avl = rs1_i;
		else if (insn_i[11:7] != 5'd0)
			avl = '1; // request vlmax
		else
			avl = vtype_q[31] ? '0 : {24'b0, vl_q}; // keep vl, nothing to keep after vill
	end

	always_comb begin
		if (vlmax == '0) begin
			vtype_next = rvv_pkg::VTYPE_RESET;
			vl_next    = '0;
		end else begin
			vtype_next = vtype_new;
			vl_next    = (avl <= {16'b0, vlmax}) ? avl[7:0] : vlmax[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= rvv_pkg::VTYPE_RESET;
			vl_q    <= '0;
		end else if (cfg_we_i) begin
			vtype_q <= vtype_next;
			vl_q    <= vl_next;
		end
	end

	assign vl_o = vl_q;

endmodule

// ==== design/rvv_issue.sv ====
`timescale 1ns/1ps

module rvv_issue (
	input  logic                clk,
	input  logic                resetn,
	input  logic                pcpi_valid_i,
	input  rvv_pkg::word_t      insn_i,
	input  rvv_pkg::vl_t        vl_i,
	input  logic                seq_done_i,
	output logic                is_rvv_o,
	output logic                cfg_we_o,
	output rvv_pkg::cfg_kind_e  cfg_kind_o,
	output logic                seq_start_o,
	output logic                seq_store_o,
	output logic                pcpi_wait_o,
	output logic                pcpi_ready_o,
	output logic                pcpi_wr_o,
	output rvv_pkg::word_t      pcpi_rd_o
);

	rvv_pkg::issue_state_e state_q;
	logic                  wr_q; // current insn returns a scalar

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       cfg_form_ok;
	logic       is_cfg;
	logic       is_load;
	logic       is_store;
	logic       unit_e32; // unit-stride, nf 0, 32-bit elements
	logic       accept;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];

	// configuration form from the top bits
	always_comb begin
		cfg_form_ok = 1'b1;
		cfg_kind_o  = rvv_pkg::CFG_VSETVLI;
		if (!insn_i[31])
			cfg_kind_o = rvv_pkg::CFG_VSETVLI;
		else if (insn_i[31:30] == 2'b11)
			cfg_kind_o = rvv_pkg::CFG_VSETIVLI;
		else if (insn_i[31:25] == 7'b1000000)
			cfg_kind_o = rvv_pkg::CFG_VSETVL;
		else
			cfg_form_ok = 1'b0;
	end

	assign is_cfg = opcode == rvv_pkg::OPC_VECTOR && funct3 == rvv_pkg::FUNCT3_CFG && cfg_form_ok;

	// nf, mew and mop all zero, lumop/sumop zero
	assign unit_e32 = funct3 == rvv_pkg::WIDTH_E32 && insn_i[31:26] == 6'b0
		&& insn_i[24:20] == 5'b0;
	assign is_load  = opcode == rvv_pkg::OPC_VLOAD && unit_e32;
	assign is_store = opcode == rvv_pkg::OPC_VSTORE && unit_e32;

	assign is_rvv_o = is_cfg | is_load | is_store;

	assign accept      = pcpi_valid_i && state_q == rvv_pkg::ISS_IDLE && is_rvv_o;
	assign cfg_we_o    = accept && is_cfg; // csr updates on the accept edge
	assign seq_start_o = accept && (is_load || is_store);
	assign seq_store_o = is_store; // insn held steady by the core

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= rvv_pkg::ISS_IDLE;
			wr_q    <= 1'b0;
		end else begin
			case (state_q)
				rvv_pkg::ISS_IDLE: begin
					if (accept) begin
						wr_q    <= is_cfg;
						state_q <= is_cfg ? rvv_pkg::ISS_RESP : rvv_pkg::ISS_BUSY;
					end
				end
				rvv_pkg::ISS_BUSY: begin
					if (seq_done_i)
						state_q <= rvv_pkg::ISS_RESP;
				end
				rvv_pkg::ISS_RESP: state_q <= rvv_pkg::ISS_IDLE;
				default: state_q <= rvv_pkg::ISS_IDLE;
			endcase
		end
	end

	assign pcpi_wait_o  = state_q == rvv_pkg::ISS_BUSY;
	assign pcpi_ready_o = state_q == rvv_pkg::ISS_RESP;
	assign pcpi_wr_o    = pcpi_ready_o && wr_q;
	assign pcpi_rd_o    = pcpi_wr_o ? {24'b0, vl_i} : '0; // new vl, csr already updated

endmodule

// ==== design/rvv_mem_seq.sv ====
`timescale 1ns/1ps

module rvv_mem_seq (
	input  logic                clk,
	input  logic                resetn,
	input  logic                start_i,
	input  logic                store_i,
	input  rvv_pkg::vreg_addr_t vd_i,
	input  logic                vm_i,
	input  rvv_pkg::word_t      base_i,
	input  rvv_pkg::vl_t        vl_i,
	input  rvv_pkg::vreg_t      v0_i,
	output rvv_pkg::vreg_addr_t raddr_o,
	input  rvv_pkg::vreg_t      rdata_i,
	output logic                we_o,
	output rvv_pkg::vreg_addr_t waddr_o,
	output rvv_pkg::vreg_t      wdata_o,
	output logic                mem_req_o,
	output logic                mem_store_o,
	output rvv_pkg::word_t      mem_addr_o,
	output rvv_pkg::word_t      mem_wdata_o,
	output logic [3:0]          mem_strb_o,
	input  rvv_pkg::word_t      mem_rdata_i,
	input  logic                mem_done_i,
	output logic                done_o
);

	rvv_pkg::seq_state_e state_q;
	rvv_pkg::vl_t        idx_q;  // element index
	logic                done_q;

	rvv_pkg::vl_t   reg_off;  // register offset from vd
	logic [6:0]     word_lsb; // bit position of the element inside the register
	rvv_pkg::word_t sel_word;
	logic           active;
	logic           last_elem;

	assign reg_off  = rvv_pkg::vl_t'(idx_q / rvv_pkg::WORDS_PER_VREG);
	assign word_lsb = 7'((idx_q % rvv_pkg::WORDS_PER_VREG) * 32);

	assign raddr_o  = vd_i + rvv_pkg::vreg_addr_t'(reg_off);
	assign sel_word = rdata_i[word_lsb +: 32];

	// v0 bit i gates element i when vm is clear
	assign active    = vm_i || v0_i[idx_q[6:0]];
	assign last_elem = idx_q == vl_i - rvv_pkg::vl_t'(1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= rvv_pkg::SEQ_IDLE;
			idx_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				rvv_pkg::SEQ_IDLE: begin
					if (start_i) begin
						idx_q <= '0;
						if (vl_i == '0)
							done_q <= 1'b1; // nothing to move
						else
							state_q <= rvv_pkg::SEQ_REQ;
					end
				end
				rvv_pkg::SEQ_REQ: state_q <= rvv_pkg::SEQ_WAIT; // one-cycle request
				rvv_pkg::SEQ_WAIT: begin
					if (mem_done_i) begin
						if (last_elem) begin
							done_q  <= 1'b1;
							state_q <= rvv_pkg::SEQ_IDLE;
						end else begin
							idx_q   <= idx_q + rvv_pkg::vl_t'(1);
							state_q <= rvv_pkg::SEQ_REQ;
						end
					end
				end
				default: state_q <= rvv_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign mem_req_o   = state_q == rvv_pkg::SEQ_REQ;
	assign mem_store_o = store_i;
	assign mem_addr_o  = base_i + {22'b0, idx_q, 2'b00}; // base + 4*i
	assign mem_wdata_o = sel_word;
	assign mem_strb_o  = (store_i && active) ? 4'hf : 4'h0; // masked store keeps the slot

	// load write-back on the edge that samples done
	assign we_o    = state_q == rvv_pkg::SEQ_WAIT && mem_done_i && !store_i && active;
	assign waddr_o = raddr_o;

	always_comb begin
		wdata_o = rdata_i;
		wdata_o[word_lsb +: 32] = mem_rdata_i;
	end

	assign done_o = done_q;

endmodule

// ==== design/rvv_pkg.sv ====
package rvv_pkg;

	// vector unit geometry
	localparam int VLEN           = 128;
	localparam int NUM_VREGS      = 32;
	localparam int WORDS_PER_VREG = VLEN / 32;

	typedef logic [31:0]     word_t;      // scalar, address or memory word
	typedef logic [VLEN-1:0] vreg_t;      // one whole vector register
	typedef logic [4:0]      vreg_addr_t; // register number
	typedef logic [7:0]      vl_t;        // element count, vlmax tops out at 128
	typedef logic [31:0]     vtype_t;

	// major opcodes
	localparam logic [6:0] OPC_VECTOR = 7'b1010111;
	localparam logic [6:0] OPC_VLOAD  = 7'b0000111;
	localparam logic [6:0] OPC_VSTORE = 7'b0100111;

	localparam logic [2:0] FUNCT3_CFG = 3'b111; // vsetvl family under OPC_VECTOR
	localparam logic [2:0] WIDTH_E32  = 3'b110; // 32-bit elements in memory

	localparam vtype_t VTYPE_RESET = 32'h8000_0000; // only vill set

	// which configuration form is being executed
	typedef enum logic [1:0] {
		CFG_VSETVLI,
		CFG_VSETIVLI,
		CFG_VSETVL
	} cfg_kind_e;

	// pcpi side of the coprocessor
	typedef enum logic [1:0] {
		ISS_IDLE,
		ISS_BUSY, // memory op in flight
		ISS_RESP  // ready pulse
	} issue_state_e;

	// per-element memory walk
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQ,
		SEQ_WAIT
	} seq_state_e;

endpackage

// ==== design/rvv_vregs.sv ====
`timescale 1ns/1ps

module rvv_vregs (
	input  logic                clk,
	input  logic                resetn,
	input  rvv_pkg::vreg_addr_t raddr_i,
	output rvv_pkg::vreg_t      rdata_o,
	input  logic                we_i,
	input  rvv_pkg::vreg_addr_t waddr_i,
	input  rvv_pkg::vreg_t      wdata_i,
	output rvv_pkg::vreg_t      v0_o
);

	rvv_pkg::vreg_t regs [rvv_pkg::NUM_VREGS];
	rvv_pkg::vreg_t v0_q; // mask copy, always readable

	always_ff @(posedge clk) begin
		if (we_i)
			regs[waddr_i] <= wdata_i;
	end

	assign rdata_o = regs[raddr_i]; // async read

	// shadow follows every write to v0
	always_ff @(posedge clk) begin
		if (!resetn)
			v0_q <= '0;
		else if (we_i && waddr_i == 5'd0)
			v0_q <= wdata_i;
	end

	assign v0_o = v0_q;

endmodule

// ==== dv/rvv_coproc_asserts.sv ====
`timescale 1ns/1ps

module rvv_coproc_asserts (
	input logic clk,
	input logic resetn,
	input logic pcpi_ready_o,
	input logic pcpi_wait_o,
	input logic mem_req_o,
	input logic mem_done_i
);

	logic pending; // request out, done not yet seen

	always_ff @(posedge clk) begin
		if (!resetn)
			pending <= 1'b0;
		else if (mem_req_o)
			pending <= 1'b1;
		else if (mem_done_i)
			pending <= 1'b0;
	end

	a_ready_wait: assert property (@(posedge clk) disable iff (!resetn)
		!(pcpi_ready_o && pcpi_wait_o)) else $error("ready and wait both high");

	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_ready_o |=> !pcpi_ready_o) else $error("ready longer than one cycle");

	a_one_req: assert property (@(posedge clk) disable iff (!resetn)
		pending |-> !mem_req_o) else $error("request before previous done");

	a_reset: assert property (@(posedge clk)
		!resetn |=> !pcpi_ready_o && !pcpi_wait_o && !mem_req_o)
		else $error("outputs active after reset");

endmodule

bind rvv_coproc_top rvv_coproc_asserts u_asserts (.*);

// ==== dv/rvv_coproc_tb.sv ====
`timescale 1ns/1ps

module rvv_coproc_tb;

	localparam int K_CFG   = 0;
	localparam int K_LOAD  = 1;
	localparam int K_STORE = 2;
	localparam int K_NONE  = 3;
	localparam int MAX_ELEMS = 32; // largest vl reached by the table

	logic                clk;
	logic                resetn;
	logic                pcpi_valid_i;
	rvv_pkg::word_t      pcpi_insn_i;
	rvv_pkg::word_t      pcpi_rs1_i;
	rvv_pkg::word_t      pcpi_rs2_i;
	logic                pcpi_wr_o;
	rvv_pkg::word_t      pcpi_rd_o;
	logic                pcpi_wait_o;
	logic                pcpi_ready_o;
	logic                pcpi_is_rvv_o;
	logic                mem_req_o;
	logic                mem_store_o;
	rvv_pkg::word_t      mem_addr_o;
	rvv_pkg::word_t      mem_wdata_o;
	logic [3:0]          mem_strb_o;
	rvv_pkg::word_t      mem_rdata_i;
	logic                mem_done_i;

	// stimulus table
	int             tab_kind [$];
	rvv_pkg::word_t tab_insn [$];
	rvv_pkg::word_t tab_rs1  [$];
	rvv_pkg::word_t tab_rs2  [$];
	rvv_pkg::word_t tab_exp  [$]; // expected vl for config rows

	rvv_pkg::word_t st_addr [$]; // stores seen by the memory model
	rvv_pkg::word_t st_data [$];
	logic [3:0]     st_strb [$];
	int             req_count;
	int             cycles = 0;
	int             limit;
	rvv_pkg::word_t ref_regs [32][4]; // expected register contents
	int             cur_vl;

	rvv_coproc_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// load data as a function of the full address
	function automatic rvv_pkg::word_t mem_pattern(rvv_pkg::word_t addr);
		return addr ^ 32'h5a5a_0f0f ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic rvv_pkg::word_t enc_vsetvli(logic [4:0] rd, logic [4:0] rs1,
		logic [2:0] sew, logic [2:0] lmul);
		return {1'b0, 5'b0, sew, lmul, rs1, 3'b111, rd, 7'b1010111};
	endfunction

	function automatic rvv_pkg::word_t enc_vsetivli(logic [4:0] rd, logic [4:0] uimm,
		logic [2:0] sew, logic [2:0] lmul);
		return {2'b11, 4'b0, sew, lmul, uimm, 3'b111, rd, 7'b1010111};
	endfunction

	function automatic rvv_pkg::word_t enc_vsetvl(logic [4:0] rd, logic [4:0] rs1,
		logic [4:0] rs2);
		return {7'b1000000, rs2, rs1, 3'b111, rd, 7'b1010111};
	endfunction

	// unit-stride e32 load or store, base in x10
	function automatic rvv_pkg::word_t enc_vmem(logic store, logic vm, logic [4:0] vd);
		return {6'b0, vm, 5'b0, 5'd10, 3'b110, vd, store ? 7'b0100111 : 7'b0000111};
	endfunction

	task automatic add_entry(int kind, rvv_pkg::word_t insn, rvv_pkg::word_t rs1,
		rvv_pkg::word_t rs2, rvv_pkg::word_t exp);
		tab_kind.push_back(kind);
		tab_insn.push_back(insn);
		tab_rs1.push_back(rs1);
		tab_rs2.push_back(rs2);
		tab_exp.push_back(exp);
	endtask

	task automatic fail_run(string msg);
		$display("error %0t: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_rd(rvv_pkg::word_t got, rvv_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("rd is %0d, expected %0d", got, exp));
	endtask

	task automatic check_store(rvv_pkg::word_t addr, rvv_pkg::word_t data, logic [3:0] strb,
		rvv_pkg::word_t exp_addr, rvv_pkg::word_t exp_data, logic [3:0] exp_strb);
		if (addr !== exp_addr || data !== exp_data || strb !== exp_strb)
			fail_run($sformatf("store %h/%h/%b, expected %h/%h/%b",
				addr, data, strb, exp_addr, exp_data, exp_strb));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
			fail_run($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// memory model, 1 to 4 cycles per request
	initial begin
		rvv_pkg::word_t addr;
		int             delay;
		mem_done_i  = 1'b0;
		mem_rdata_i = '0;
		req_count   = 0;
		forever begin
			@(negedge clk);
			if (mem_req_o) begin
				addr = mem_addr_o;
				req_count++;
				if (mem_store_o) begin
					st_addr.push_back(addr);
					st_data.push_back(mem_wdata_o);
					st_strb.push_back(mem_strb_o);
				end
				delay = $urandom_range(4, 1);
				repeat (delay) @(posedge clk);
				#1 mem_done_i = 1'b1;
				mem_rdata_i = mem_pattern(addr);
				@(posedge clk);
				#1 mem_done_i = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: the DUT stopped responding within %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic issue_insn(rvv_pkg::word_t insn, rvv_pkg::word_t rs1, rvv_pkg::word_t rs2,
		output rvv_pkg::word_t rd, output logic wr, output int lat);
		@(posedge clk);
		#1 pcpi_valid_i = 1'b1;
		pcpi_insn_i = insn;
		pcpi_rs1_i  = rs1;
		pcpi_rs2_i  = rs2;
		lat = 0;
		@(negedge clk);
		check_flag(pcpi_is_rvv_o, 1'b1, "is_rvv on claimed insn");
		while (!pcpi_ready_o) begin
			check_flag(pcpi_wait_o, lat != 0, "pcpi_wait before ready"); // low in the accept cycle
			lat++;
			@(negedge clk);
		end
		rd = pcpi_rd_o;
		wr = pcpi_wr_o;
		@(posedge clk);
		#1 pcpi_valid_i = 1'b0;
	endtask

	task automatic run_entry(int n);
		rvv_pkg::word_t rd;
		logic           wr;
		int             lat;
		int             reqs;
		int             vd;
		logic           act;
		vd   = int'(tab_insn[n][11:7]);
		reqs = req_count;
		if (tab_kind[n] == K_NONE) begin
			@(posedge clk);
			#1 pcpi_valid_i = 1'b1;
			pcpi_insn_i = tab_insn[n];
			repeat (4) begin
				@(negedge clk);
				check_flag(pcpi_is_rvv_o, 1'b0, "is_rvv on unclaimed insn");
				check_flag(pcpi_ready_o | pcpi_wait_o, 1'b0, "response to unclaimed insn");
			end
			@(posedge clk);
			#1 pcpi_valid_i = 1'b0;
			check_flag(req_count == reqs, 1'b1, "memory traffic on unclaimed insn");
			return;
		end
		issue_insn(tab_insn[n], tab_rs1[n], tab_rs2[n], rd, wr, lat);
		if (tab_kind[n] == K_CFG) begin
			check_flag(wr, 1'b1, "pcpi_wr on config");
			check_flag(lat == 1, 1'b1, "one-cycle config latency");
			check_rd(rd, tab_exp[n]);
			cur_vl = int'(tab_exp[n]);
			return;
		end
		check_flag(wr, 1'b0, "pcpi_wr on memory op");
		check_rd(rd, 32'h0);
		check_flag(req_count - reqs == cur_vl, 1'b1, "request count equals vl");
		check_flag(st_addr.size() == (tab_kind[n] == K_STORE ? cur_vl : 0), 1'b1,
			"store count on memory op");
		for (int i = 0; i < cur_vl; i++) begin
			act = tab_insn[n][25] || ref_regs[i / 128][(i / 32) % 4][i % 32];
			if (tab_kind[n] == K_LOAD && act)
				ref_regs[vd + i / 4][i % 4] = mem_pattern(tab_rs1[n] + 4 * i);
			else if (tab_kind[n] == K_STORE)
				check_store(st_addr[i], st_data[i], st_strb[i], tab_rs1[n] + 4 * i,
					ref_regs[vd + i / 4][i % 4], act ? 4'hf : 4'h0);
		end
		st_addr.delete();
		st_data.delete();
		st_strb.delete();
	endtask

	initial begin
		void'($urandom(32'hd6c));
		resetn       = 1'b0;
		pcpi_valid_i = 1'b0;
		pcpi_insn_i  = '0;
		pcpi_rs1_i   = '0;
		pcpi_rs2_i   = '0;
		cur_vl       = 0;
		add_entry(K_CFG, enc_vsetvli(1, 10, 0, 0), 100, 0, 16);  // e8 m1
		add_entry(K_CFG, enc_vsetvli(1, 10, 1, 1), 9, 0, 9);     // e16 m2
		add_entry(K_CFG, enc_vsetvli(1, 10, 2, 7), 5, 0, 2);     // e32 mf2
		add_entry(K_CFG, enc_vsetvli(1, 10, 0, 5), 1, 0, 1);     // e8 mf8
		add_entry(K_CFG, enc_vsetvli(1, 10, 3, 3), 200, 0, 16);  // e64 m8
		add_entry(K_CFG, enc_vsetivli(1, 13, 2, 2), 0, 0, 13);
		add_entry(K_CFG, enc_vsetivli(1, 31, 2, 0), 0, 0, 4);    // capped
		add_entry(K_CFG, enc_vsetvli(1, 0, 1, 2), 0, 0, 32);     // avl = vlmax
		add_entry(K_CFG, enc_vsetvli(0, 0, 0, 2), 0, 0, 32);     // keeps vl
		add_entry(K_CFG, enc_vsetvli(1, 10, 2, 4), 7, 0, 0);     // reserved lmul
		add_entry(K_LOAD, enc_vmem(0, 1, 8), 32'h5000, 0, 0);    // vl 0, no traffic
		add_entry(K_CFG, enc_vsetvl(1, 10, 11), 6, 32'h11, 6);   // e32 m2
		add_entry(K_LOAD, enc_vmem(0, 1, 4), 32'h1000, 0, 0);
		add_entry(K_STORE, enc_vmem(1, 1, 4), 32'h2000, 0, 0);
		add_entry(K_LOAD, enc_vmem(0, 1, 0), 32'h3000, 0, 0);    // mask into v0
		add_entry(K_STORE, enc_vmem(1, 0, 4), 32'h2100, 0, 0);
		add_entry(K_LOAD, enc_vmem(0, 0, 4), 32'h4000, 0, 0);    // masked overwrite
		add_entry(K_STORE, enc_vmem(1, 1, 4), 32'h2200, 0, 0);
		add_entry(K_NONE, 32'h0000_0057, 0, 0, 0);               // vadd.vv
		limit = tab_kind.size() * (MAX_ELEMS * 6 + 10) + 20;
		repeat (8) @(posedge clk);
		#1 resetn = 1'b1;
		for (int n = 0; n < tab_kind.size(); n++)
			run_entry(n);
		repeat (2) @(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module rvv_coproc_tb -o rvv_sim \
	&& ./obj_dir/rvv_sim \
	|| exit 1
